/* dv/mem_model.sv */
`timescale 1ns/1ns
`include "mem_route_defines.svh"

module mem_model (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  pause,
    input  int                    lat_max,
    input  logic                  mem_req_valid,
    input  logic                  mem_req_write,
    input  mem_route_pkg::addr_t  mem_req_addr,
    input  mem_route_pkg::data_t  mem_req_wdata,
    input  mem_route_pkg::strb_t  mem_req_wstrb,
    output logic                  mem_credit_return,
    output logic                  mem_rsp_valid,
    output mem_route_pkg::data_t  mem_rsp_data
);

    localparam mem_route_pkg::data_t FILL = 64'h5a5a_5a5a_5a5a_5a5a;

    mem_route_pkg::data_t words [mem_route_pkg::addr_t];
    mem_route_pkg::data_t rd_data_q [$];
    int                   rd_due_q [$];
    int                   wr_due_q [$];
    mem_route_pkg::data_t word;
    mem_route_pkg::data_t rsp_data;
    logic [31:0]          lfsr;
    int                   cycle;
    int                   last_due;
    int                   owed;
    int                   delay;
    logic                 rsp_now;
    logic                 credit_now;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // three bits per draw, one LFSR step per bit
    task automatic draw_delay(output int d);
        d = 0;
        repeat (3) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        d = d % (lat_max + 1);
    endtask

    initial begin
        mem_credit_return = 1'b0;
        mem_rsp_valid     = 1'b0;
        mem_rsp_data      = '0;
    end

    ////////////////////////////////////////////////////////////
    // sample mid-cycle, drive just after the next rising edge
    always begin
        @(negedge CLK);
        rsp_now    = 1'b0;
        credit_now = 1'b0;
        if (!RSTN) begin
            words.delete();
            rd_data_q.delete();
            rd_due_q.delete();
            wr_due_q.delete();
            lfsr     = 32'd95278;
            cycle    = 0;
            last_due = -1;
            owed     = 0;
            rsp_data = '0;
        end else begin
            cycle++;
            if (mem_req_valid) begin
                draw_delay(delay);
                word = words.exists(mem_req_addr) ? words[mem_req_addr] : (mem_req_addr ^ FILL);
                if (mem_req_write) begin
                    for (int b = 0; b < `MEM_STRB_W; b++) begin
                        if (mem_req_wstrb[b]) begin
                            word[b*8 +: 8] = mem_req_wdata[b*8 +: 8];
                        end
                    end
                    words[mem_req_addr] = word;
                    wr_due_q.push_back(cycle + delay);
                end else begin
                    // reads answer in issue order
                    last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
                    rd_data_q.push_back(word);
                    rd_due_q.push_back(last_due);
                end
            end
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                rsp_now  = 1'b1;
                rsp_data = rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
                owed++;
            end
            if (wr_due_q.size() > 0 && wr_due_q[0] <= cycle) begin
                void'(wr_due_q.pop_front());
                owed++;
            end
            // a read's credit never leaves before its response
            if (!pause && owed > 0) begin
                credit_now = 1'b1;
                owed--;
            end
        end
        @(posedge CLK);
        #2;
        mem_rsp_valid     = rsp_now;
        mem_rsp_data      = rsp_data;
        mem_credit_return = credit_now;
    end

endmodule

/* dv/mem_router_tb.sv */
`timescale 1ns/1ns
`include "mem_route_defines.svh"

module mem_router_tb;

    localparam mem_route_pkg::data_t PAT = 64'h5a5a_5a5a_5a5a_5a5a;
    localparam mem_route_pkg::addr_t CON = `CONSOLE_ADDR;

    typedef struct packed {
        logic [2:0]           valid;
        mem_route_pkg::addr_t itlb_addr;
        mem_route_pkg::addr_t dtlb_addr;
        logic                 core_write;
        mem_route_pkg::addr_t core_addr;
        mem_route_pkg::data_t core_data;
        mem_route_pkg::strb_t core_strb;
        logic [2:0]           lat;
        logic                 pause;
        logic                 stall;
        mem_route_pkg::data_t exp_itlb;
        mem_route_pkg::data_t exp_dtlb;
        mem_route_pkg::data_t exp_core;
    } row_t;

    logic                 CLK;
    logic                 RSTN;
    logic                 itlb_walk_valid;
    mem_route_pkg::addr_t itlb_walk_addr;
    logic                 itlb_walk_ready;
    logic                 itlb_walk_rsp_valid;
    mem_route_pkg::data_t itlb_walk_rsp_data;
    logic                 dtlb_walk_valid;
    mem_route_pkg::addr_t dtlb_walk_addr;
    logic                 dtlb_walk_ready;
    logic                 dtlb_walk_rsp_valid;
    mem_route_pkg::data_t dtlb_walk_rsp_data;
    logic                 core_req_valid;
    logic                 core_req_write;
    mem_route_pkg::addr_t core_req_addr;
    mem_route_pkg::data_t core_req_wdata;
    mem_route_pkg::strb_t core_req_wstrb;
    logic                 core_req_ready;
    logic                 core_rsp_valid;
    mem_route_pkg::data_t core_rsp_data;
    logic                 console_write;
    mem_route_pkg::char_t console_char;
    logic                 mem_req_valid;
    logic                 mem_req_write;
    mem_route_pkg::addr_t mem_req_addr;
    mem_route_pkg::data_t mem_req_wdata;
    mem_route_pkg::strb_t mem_req_wstrb;
    logic                 mem_credit_return;
    logic                 mem_rsp_valid;
    mem_route_pkg::data_t mem_rsp_data;
    logic                 model_pause;
    int                   model_lat;

    row_t                 rows [$];
    mem_route_pkg::addr_t mem_addr_q [$];
    mem_route_pkg::data_t itlb_q [$];
    mem_route_pkg::data_t dtlb_q [$];
    mem_route_pkg::data_t core_q [$];
    mem_route_pkg::char_t char_q [$];
    int                   mem_req_total;
    int                   cycles;
    int                   cycle_limit;

    mem_router_top mem_router_top_inst (.*);

    mem_model mem_model_inst (
        .CLK, .RSTN, .pause(model_pause), .lat_max(model_lat),
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata, .mem_req_wstrb,
        .mem_credit_return, .mem_rsp_valid, .mem_rsp_data
    );

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // checks
    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input mem_route_pkg::data_t got, input mem_route_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            stop_failed($sformatf("** Error at %0t ns: %s data %h, expected %h",
                                  $time, what, got, exp));
        end
    endtask

    task automatic check_char(input mem_route_pkg::char_t got, input mem_route_pkg::char_t exp,
                              input string what);
        if (got !== exp) begin
            stop_failed($sformatf("** Error at %0t ns: %s char %h, expected %h",
                                  $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input mem_route_pkg::addr_t got, input mem_route_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            stop_failed($sformatf("** Error at %0t ns: %s addr %h, expected %h",
                                  $time, what, got, exp));
        end
    endtask

    // everything the DUT puts out, sampled mid-cycle
    always @(negedge CLK) begin
        if (RSTN) begin
            if (mem_req_valid) begin
                mem_addr_q.push_back(mem_req_addr);
                mem_req_total++;
            end
            if (itlb_walk_rsp_valid) itlb_q.push_back(itlb_walk_rsp_data);
            if (dtlb_walk_rsp_valid) dtlb_q.push_back(dtlb_walk_rsp_data);
            if (core_rsp_valid) core_q.push_back(core_rsp_data);
            if (console_write) char_q.push_back(console_char);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_failed($sformatf("timeout: run still busy after %0d cycles", cycles));
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus table
    task automatic fill_table();
        // valid {itlb,dtlb,core}, itlb addr, dtlb addr, core write, core addr, core data,
        // core strobe, max latency, pause, stall, expected itlb, dtlb and core data
        rows.push_back('{3'b001, '0, '0, 1'b0, 64'h1000, '0, '0, 3'd3, 1'b1, 1'b0,
                         '0, '0, 64'h1000 ^ PAT});
        rows.push_back('{3'b001, '0, '0, 1'b0, 64'h1008, '0, '0, 3'd3, 1'b1, 1'b0,
                         '0, '0, 64'h1008 ^ PAT});
        rows.push_back('{3'b001, '0, '0, 1'b0, 64'h1010, '0, '0, 3'd3, 1'b1, 1'b0,
                         '0, '0, 64'h1010 ^ PAT});
        rows.push_back('{3'b001, '0, '0, 1'b0, 64'h1018, '0, '0, 3'd3, 1'b1, 1'b0,
                         '0, '0, 64'h1018 ^ PAT});
        // console store with the model paused and no credit left
        rows.push_back('{3'b001, '0, '0, 1'b1, CON, 64'h41, 8'h01, 3'd0, 1'b1, 1'b0,
                         '0, '0, '0});
        // credits are gone here, so this one waits for the model
        rows.push_back('{3'b001, '0, '0, 1'b0, 64'h1020, '0, '0, 3'd3, 1'b1, 1'b1,
                         '0, '0, 64'h1020 ^ PAT});
        rows.push_back('{3'b001, '0, '0, 1'b1, 64'h2000, 64'h1122_3344_5566_7788, 8'h0f,
                         3'd2, 1'b0, 1'b0, '0, '0, '0});
        // low four bytes replaced by the store
        rows.push_back('{3'b001, '0, '0, 1'b0, 64'h2000, '0, '0, 3'd4, 1'b0, 1'b0,
                         '0, '0, 64'h5a5a_5a5a_5566_7788});
        rows.push_back('{3'b100, 64'h4000, '0, 1'b0, '0, '0, '0, 3'd5, 1'b0, 1'b0,
                         64'h4000 ^ PAT, '0, '0});
        rows.push_back('{3'b010, '0, 64'h4100, 1'b0, '0, '0, '0, 3'd1, 1'b0, 1'b0,
                         '0, 64'h4100 ^ PAT, '0});
        rows.push_back('{3'b111, 64'h5000, 64'h5100, 1'b0, 64'h5200, '0, '0, 3'd7, 1'b0,
                         1'b0, 64'h5000 ^ PAT, 64'h5100 ^ PAT, 64'h5200 ^ PAT});
        rows.push_back('{3'b111, 64'h6100, 64'h6200, 1'b1, 64'h6000,
                         64'hcafe_f00d_dead_beef, 8'hff, 3'd7, 1'b0, 1'b0,
                         64'h6100 ^ PAT, 64'h6200 ^ PAT, '0});
        rows.push_back('{3'b111, 64'h6000, 64'h2000, 1'b1, CON, 64'h5a, 8'h01, 3'd7, 1'b0,
                         1'b0, 64'hcafe_f00d_dead_beef, 64'h5a5a_5a5a_5566_7788, '0});
        rows.push_back('{3'b011, '0, 64'h6008, 1'b0, 64'h6000, '0, '0, 3'd6, 1'b0, 1'b0,
                         '0, 64'h6008 ^ PAT, 64'hcafe_f00d_dead_beef});
        rows.push_back('{3'b001, '0, '0, 1'b1, 64'h6000, 64'h0123_4567_89ab_cdef, 8'hf0,
                         3'd5, 1'b0, 1'b0, '0, '0, '0});
        rows.push_back('{3'b101, 64'h7000, '0, 1'b0, 64'h6000, '0, '0, 3'd7, 1'b0, 1'b0,
                         64'h7000 ^ PAT, '0, 64'h0123_4567_dead_beef});
    endtask

    ////////////////////////////////////////////////////////////
    // one row, entered and left 2 ns after a rising edge
    task automatic run_row(input row_t r, input int idx);
        logic [2:0]           pend;
        logic [2:0]           took;
        logic                 console;
        int                   n_rsp;
        int                   n_core;
        mem_route_pkg::addr_t exp_addr [$];

        console = r.valid[0] && r.core_write && (r.core_addr == CON);
        n_core  = (r.valid[0] && !r.core_write) ? 1 : 0;
        n_rsp   = int'(r.valid[2]) + int'(r.valid[1]) + n_core;
        if (r.valid[2]) exp_addr.push_back(r.itlb_addr);
        if (r.valid[1]) exp_addr.push_back(r.dtlb_addr);
        if (r.valid[0] && !console) exp_addr.push_back(r.core_addr);
        mem_addr_q.delete();
        itlb_q.delete();
        dtlb_q.delete();
        core_q.delete();
        char_q.delete();

        model_pause    = r.pause;
        model_lat      = int'(r.lat);
        itlb_walk_addr = r.itlb_addr;
        dtlb_walk_addr = r.dtlb_addr;
        core_req_write = r.core_write;
        core_req_addr  = r.core_addr;
        core_req_wdata = r.core_data;
        core_req_wstrb = r.core_strb;
        {itlb_walk_valid, dtlb_walk_valid, core_req_valid} = r.valid;

        if (r.stall) begin
            repeat (20) begin
                @(negedge CLK);
                if (itlb_walk_ready || dtlb_walk_ready || core_req_ready || mem_req_valid) begin
                    stop_failed($sformatf("row %0d: a request moved with no credit left", idx));
                end
            end
            if (mem_req_total != `MEM_CREDITS) begin
                stop_failed($sformatf("row %0d: %0d requests went out on the reset credits",
                                      idx, mem_req_total));
            end
            @(posedge CLK);
            #2;
            model_pause = 1'b0;
        end

        // hold each valid until its transfer edge
        pend = r.valid;
        while (pend != 3'b000) begin
            @(negedge CLK);
            took = pend & {itlb_walk_ready, dtlb_walk_ready, core_req_ready};
            @(posedge CLK);
            #2;
            pend = pend & ~took;
            {itlb_walk_valid, dtlb_walk_valid, core_req_valid} = pend;
        end

        while (mem_addr_q.size() < exp_addr.size() ||
               itlb_q.size() + dtlb_q.size() + core_q.size() < n_rsp ||
               char_q.size() < int'(console)) begin
            @(posedge CLK);
        end
        // a few quiet cycles to catch stray pulses
        repeat (3) @(posedge CLK);
        #2;

        if (mem_addr_q.size() != exp_addr.size()) begin
            stop_failed($sformatf("row %0d: %0d memory requests seen, %0d expected",
                                  idx, mem_addr_q.size(), exp_addr.size()));
        end
        foreach (exp_addr[i]) begin
            check_addr(mem_addr_q[i], exp_addr[i], $sformatf("row %0d request %0d", idx, i));
        end
        if (itlb_q.size() != int'(r.valid[2]) || dtlb_q.size() != int'(r.valid[1]) ||
            core_q.size() != n_core) begin
            stop_failed($sformatf("row %0d: read responses came back on the wrong ports", idx));
        end
        if (r.valid[2]) check_data(itlb_q[0], r.exp_itlb, $sformatf("row %0d itlb", idx));
        if (r.valid[1]) check_data(dtlb_q[0], r.exp_dtlb, $sformatf("row %0d dtlb", idx));
        if (n_core == 1) check_data(core_q[0], r.exp_core, $sformatf("row %0d core", idx));
        if (char_q.size() != int'(console)) begin
            stop_failed($sformatf("row %0d: %0d console pulses seen", idx, char_q.size()));
        end
        if (console) check_char(char_q[0], r.core_data[7:0], $sformatf("row %0d console", idx));
    endtask

    initial begin
        RSTN            = 1'b0;
        itlb_walk_valid = 1'b0;
        itlb_walk_addr  = '0;
        dtlb_walk_valid = 1'b0;
        dtlb_walk_addr  = '0;
        core_req_valid  = 1'b0;
        core_req_write  = 1'b0;
        core_req_addr   = '0;
        core_req_wdata  = '0;
        core_req_wstrb  = '0;
        model_pause     = 1'b0;
        model_lat       = 0;
        mem_req_total   = 0;
        cycles          = 0;
        fill_table();
        cycle_limit = rows.size() * 40 + 200;

        repeat (10) @(posedge CLK);
        #2;
        RSTN = 1'b1;

        foreach (rows[i]) begin
            run_row(rows[i], i);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* hdl/mem_credit_port.sv */
`timescale 1ns/1ns
`include "mem_route_defines.svh"

module mem_credit_port (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  issue_valid,
    input  logic                  issue_write,
    input  mem_route_pkg::addr_t  issue_addr,
    input  mem_route_pkg::data_t  issue_wdata,
    input  mem_route_pkg::strb_t  issue_wstrb,
    input  logic                  mem_credit_return,
    output logic                  credit_avail,
    output logic                  mem_req_valid,
    output logic                  mem_req_write,
    output mem_route_pkg::addr_t  mem_req_addr,
    output mem_route_pkg::data_t  mem_req_wdata,
    output mem_route_pkg::strb_t  mem_req_wstrb
);

    mem_route_pkg::credit_t credit_cnt;

    assign credit_avail = (credit_cnt != '0);

    ////////////////////////////////////////////////////////////
    // credit counter, full after reset
    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            credit_cnt <= mem_route_pkg::credit_t'(`MEM_CREDITS);
        end else begin
            // issue and return on one edge cancel
            case ({issue_valid, mem_credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // request register, one cycle from grant to memory
    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            mem_req_write <= issue_write;
            mem_req_addr  <= issue_addr;
            mem_req_wdata <= issue_wdata;
            mem_req_wstrb <= issue_wstrb;
        end
    end

    // memory returns no more credits than it was given
    a_credit_bound: assert property (@(posedge CLK) disable iff (!RSTN)
        (mem_credit_return && !issue_valid)
            |-> (credit_cnt < mem_route_pkg::credit_t'(`MEM_CREDITS)));
    // the arbiter never grants a memory request without a credit
    a_no_issue_zero: assert property (@(posedge CLK) disable iff (!RSTN)
        issue_valid |-> (credit_cnt != '0));

endmodule

/* hdl/mem_route_defines.svh */
`ifndef MEM_ROUTE_DEFINES_SVH
`define MEM_ROUTE_DEFINES_SVH

// bus widths
`define MEM_ADDR_W 64
`define MEM_DATA_W 64
`define MEM_STRB_W 8

// credits granted by memory after reset, also the in-flight tag depth
`define MEM_CREDITS 4

// console FIFO store address
`define CONSOLE_ADDR 64'h0000_0000_e000_1030

`endif

/* hdl/mem_route_pkg.sv */
`include "mem_route_defines.svh"

package mem_route_pkg;

    ////////////////////////////////////////////////////////////
    // bus fields
    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] data_t;
    typedef logic [`MEM_STRB_W-1:0] strb_t;
    typedef logic [7:0]             char_t;

    // holds 0..MEM_CREDITS inclusive
    typedef logic [$clog2(`MEM_CREDITS + 1)-1:0] credit_t;

    // who asked for an in-flight read
    typedef enum logic [1:0] {
        SRC_ITLB,
        SRC_DTLB,
        SRC_CORE
    } mem_src_t;

endpackage

/* hdl/mem_router_top.sv */
`timescale 1ns/1ns

module mem_router_top (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  itlb_walk_valid,
    input  mem_route_pkg::addr_t  itlb_walk_addr,
    output logic                  itlb_walk_ready,
    output logic                  itlb_walk_rsp_valid,
    output mem_route_pkg::data_t  itlb_walk_rsp_data,
    input  logic                  dtlb_walk_valid,
    input  mem_route_pkg::addr_t  dtlb_walk_addr,
    output logic                  dtlb_walk_ready,
    output logic                  dtlb_walk_rsp_valid,
    output mem_route_pkg::data_t  dtlb_walk_rsp_data,
    input  logic                  core_req_valid,
    input  logic                  core_req_write,
    input  mem_route_pkg::addr_t  core_req_addr,
    input  mem_route_pkg::data_t  core_req_wdata,
    input  mem_route_pkg::strb_t  core_req_wstrb,
    output logic                  core_req_ready,
    output logic                  core_rsp_valid,
    output mem_route_pkg::data_t  core_rsp_data,
    output logic                  console_write,
    output mem_route_pkg::char_t  console_char,
    output logic                  mem_req_valid,
    output logic                  mem_req_write,
    output mem_route_pkg::addr_t  mem_req_addr,
    output mem_route_pkg::data_t  mem_req_wdata,
    output mem_route_pkg::strb_t  mem_req_wstrb,
    input  logic                  mem_credit_return,
    input  logic                  mem_rsp_valid,
    input  mem_route_pkg::data_t  mem_rsp_data
);

    logic                    credit_avail;
    logic                    issue_valid;
    logic                    issue_write;
    mem_route_pkg::addr_t    issue_addr;
    mem_route_pkg::data_t    issue_wdata;
    mem_route_pkg::strb_t    issue_wstrb;
    mem_route_pkg::mem_src_t issue_src;
    logic                    read_push;

    // only reads get a response, so only reads take a tag
    assign read_push = issue_valid && !issue_write;

    req_arbiter req_arbiter_inst (
        .CLK             (CLK),
        .RSTN            (RSTN),
        .itlb_walk_valid (itlb_walk_valid),
        .itlb_walk_addr  (itlb_walk_addr),
        .itlb_walk_ready (itlb_walk_ready),
        .dtlb_walk_valid (dtlb_walk_valid),
        .dtlb_walk_addr  (dtlb_walk_addr),
        .dtlb_walk_ready (dtlb_walk_ready),
        .core_req_valid  (core_req_valid),
        .core_req_write  (core_req_write),
        .core_req_addr   (core_req_addr),
        .core_req_wdata  (core_req_wdata),
        .core_req_wstrb  (core_req_wstrb),
        .core_req_ready  (core_req_ready),
        .credit_avail    (credit_avail),
        .issue_valid     (issue_valid),
        .issue_write     (issue_write),
        .issue_addr      (issue_addr),
        .issue_wdata     (issue_wdata),
        .issue_wstrb     (issue_wstrb),
        .issue_src       (issue_src),
        .console_write   (console_write),
        .console_char    (console_char)
    );

    mem_credit_port mem_credit_port_inst (
        .CLK               (CLK),
        .RSTN              (RSTN),
        .issue_valid       (issue_valid),
        .issue_write       (issue_write),
        .issue_addr        (issue_addr),
        .issue_wdata       (issue_wdata),
        .issue_wstrb       (issue_wstrb),
        .mem_credit_return (mem_credit_return),
        .credit_avail      (credit_avail),
        .mem_req_valid     (mem_req_valid),
        .mem_req_write     (mem_req_write),
        .mem_req_addr      (mem_req_addr),
        .mem_req_wdata     (mem_req_wdata),
        .mem_req_wstrb     (mem_req_wstrb)
    );

    rsp_steer rsp_steer_inst (
        .CLK                 (CLK),
        .RSTN                (RSTN),
        .push                (read_push),
        .push_src            (issue_src),
        .mem_rsp_valid       (mem_rsp_valid),
        .mem_rsp_data        (mem_rsp_data),
        .itlb_walk_rsp_valid (itlb_walk_rsp_valid),
        .itlb_walk_rsp_data  (itlb_walk_rsp_data),
        .dtlb_walk_rsp_valid (dtlb_walk_rsp_valid),
        .dtlb_walk_rsp_data  (dtlb_walk_rsp_data),
        .core_rsp_valid      (core_rsp_valid),
        .core_rsp_data       (core_rsp_data)
    );

endmodule

/* hdl/req_arbiter.sv */
`timescale 1ns/1ns
`include "mem_route_defines.svh"

module req_arbiter (
    input  logic                     CLK,
    input  logic                     RSTN,
    input  logic                     itlb_walk_valid,
    input  mem_route_pkg::addr_t     itlb_walk_addr,
    output logic                     itlb_walk_ready,
    input  logic                     dtlb_walk_valid,
    input  mem_route_pkg::addr_t     dtlb_walk_addr,
    output logic                     dtlb_walk_ready,
    input  logic                     core_req_valid,
    input  logic                     core_req_write,
    input  mem_route_pkg::addr_t     core_req_addr,
    input  mem_route_pkg::data_t     core_req_wdata,
    input  mem_route_pkg::strb_t     core_req_wstrb,
    output logic                     core_req_ready,
    input  logic                     credit_avail,
    output logic                     issue_valid,
    output logic                     issue_write,
    output mem_route_pkg::addr_t     issue_addr,
    output mem_route_pkg::data_t     issue_wdata,
    output mem_route_pkg::strb_t     issue_wstrb,
    output mem_route_pkg::mem_src_t  issue_src,
    output logic                     console_write,
    output mem_route_pkg::char_t     console_char
);

    logic core_console;
    logic core_turn;

    // console stores never reach memory, so they need no credit
    assign core_console = core_req_write && (core_req_addr == `CONSOLE_ADDR);

    ////////////////////////////////////////////////////////////
    // fixed priority, itlb > dtlb > core
    assign itlb_walk_ready = itlb_walk_valid && credit_avail;
    assign dtlb_walk_ready = dtlb_walk_valid && !itlb_walk_valid && credit_avail;
    // core still waits behind any walker, even for the console
    assign core_turn       = core_req_valid && !itlb_walk_valid && !dtlb_walk_valid;
    assign core_req_ready  = core_turn && (core_console || credit_avail);

    // chosen request goes out in the same cycle
    always_comb begin
        issue_valid = 1'b0;
        issue_write = 1'b0;
        issue_addr  = core_req_addr;
        issue_wdata = core_req_wdata;
        issue_wstrb = core_req_wstrb;
        issue_src   = mem_route_pkg::SRC_CORE;
        if (itlb_walk_ready) begin
            issue_valid = 1'b1;
            issue_addr  = itlb_walk_addr;
            issue_src   = mem_route_pkg::SRC_ITLB;
        end else if (dtlb_walk_ready) begin
            issue_valid = 1'b1;
            issue_addr  = dtlb_walk_addr;
            issue_src   = mem_route_pkg::SRC_DTLB;
        end else if (core_req_ready && !core_console) begin
            issue_valid = 1'b1;
            issue_write = core_req_write;
        end
    end

    ////////////////////////////////////////////////////////////
    // console character strobe, one cycle after the grant
    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            console_write <= 1'b0;
            console_char  <= '0;
        end else begin
            console_write <= core_req_ready && core_console;
            if (core_req_ready && core_console) begin
                console_char <= core_req_wdata[7:0];
            end
        end
    end

    // a waiting requester keeps its request up and unchanged until the grant
    a_itlb_hold: assert property (@(posedge CLK) disable iff (!RSTN)
        (itlb_walk_valid && !itlb_walk_ready)
            |=> (itlb_walk_valid && $stable(itlb_walk_addr)));
    a_dtlb_hold: assert property (@(posedge CLK) disable iff (!RSTN)
        (dtlb_walk_valid && !dtlb_walk_ready)
            |=> (dtlb_walk_valid && $stable(dtlb_walk_addr)));
    a_core_hold: assert property (@(posedge CLK) disable iff (!RSTN)
        (core_req_valid && !core_req_ready)
            |=> (core_req_valid
                 && $stable({core_req_write, core_req_addr, core_req_wdata, core_req_wstrb})));

endmodule

/* hdl/rsp_steer.sv */
`timescale 1ns/1ns
`include "mem_route_defines.svh"

module rsp_steer (
    input  logic                     CLK,
    input  logic                     RSTN,
    input  logic                     push,
    input  mem_route_pkg::mem_src_t  push_src,
    input  logic                     mem_rsp_valid,
    input  mem_route_pkg::data_t     mem_rsp_data,
    output logic                     itlb_walk_rsp_valid,
    output mem_route_pkg::data_t     itlb_walk_rsp_data,
    output logic                     dtlb_walk_rsp_valid,
    output mem_route_pkg::data_t     dtlb_walk_rsp_data,
    output logic                     core_rsp_valid,
    output mem_route_pkg::data_t     core_rsp_data
);

    localparam int DEPTH = `MEM_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    mem_route_pkg::mem_src_t src_fifo [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    mem_route_pkg::credit_t  fill;
    mem_route_pkg::mem_src_t head_src;
    mem_route_pkg::data_t    rsp_data_q;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_src = src_fifo[rd_ptr];

    ////////////////////////////////////////////////////////////
    // in-flight tags, oldest read at rd_ptr
    always_ff @(posedge CLK) begin
        if (push) begin
            src_fifo[wr_ptr] <= push_src;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (mem_rsp_valid) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, mem_rsp_valid})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // response pulse to the owner of the head tag
    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            itlb_walk_rsp_valid <= 1'b0;
            dtlb_walk_rsp_valid <= 1'b0;
            core_rsp_valid      <= 1'b0;
        end else begin
            itlb_walk_rsp_valid <= mem_rsp_valid && (head_src == mem_route_pkg::SRC_ITLB);
            dtlb_walk_rsp_valid <= mem_rsp_valid && (head_src == mem_route_pkg::SRC_DTLB);
            core_rsp_valid      <= mem_rsp_valid && (head_src == mem_route_pkg::SRC_CORE);
        end
    end

    // one data register, only the valid tells the ports apart
    always_ff @(posedge CLK) begin
        if (mem_rsp_valid) begin
            rsp_data_q <= mem_rsp_data;
        end
    end

    assign itlb_walk_rsp_data = rsp_data_q;
    assign dtlb_walk_rsp_data = rsp_data_q;
    assign core_rsp_data      = rsp_data_q;

    // credits must keep reads in flight within the tag depth
    a_no_push_full: assert property (@(posedge CLK) disable iff (!RSTN)
        push |-> (fill != mem_route_pkg::credit_t'(DEPTH)));
    // memory never answers a read it was not sent
    a_no_rsp_empty: assert property (@(posedge CLK) disable iff (!RSTN)
        mem_rsp_valid |-> (fill != '0));

endmodule

/* list.f */
+incdir+hdl
hdl/mem_route_pkg.sv
hdl/req_arbiter.sv
hdl/rsp_steer.sv
hdl/mem_credit_port.sv
hdl/mem_router_top.sv
dv/mem_model.sv
dv/mem_router_tb.sv

/* run.sh */
#!/bin/sh
# build and run the memory router simulation, exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mem_router_tb \
    -f list.f \
    -Mdir obj_dir -o mem_router_sim

./obj_dir/mem_router_sim
